//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_mci_trace
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "Test passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_mci_trace.sv
// Testbench for the MCU instruction trace buffer
// Replays the golden operation file and checks every read against a ring model
`timescale 1ns/1ns

module tb_mci_trace;
    import mci_trace_pkg::*;

    localparam int DEPTH = 8;
    localparam int IDX_W = $clog2(DEPTH);

    logic                    clk;
    logic                    reset_i;
    logic                    debug_en_i;
    logic                    trace_valid_i;
    logic [TRACE_WORD_W-1:0] trace_addr_i;
    logic [TRACE_WORD_W-1:0] trace_insn_i;
    logic                    rd_req_i;
    trace_cmd_e              rd_cmd_i;
    logic [IDX_W-1:0]        rd_index_i;
    logic                    rd_ack_o;
    logic [TRACE_WORD_W-1:0] rd_data_o;

    // Operations loaded from the golden file
    byte         op_kind [$];
    logic [31:0] op_a [$];
    logic [31:0] op_b [$];
    logic [31:0] op_c [$];
    int          golden_lines;
    bit          golden_loaded;

    // Reference model of the ring
    logic [31:0]      model_addr [DEPTH];
    logic [31:0]      model_insn [DEPTH];
    logic [IDX_W-1:0] model_ptr;
    logic             model_wrapped;

    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;
    int          tests;

    mci_trace_top #(
        .TRACE_DEPTH (DEPTH)
    ) i_mci_trace_top (
        .clk           (clk),
        .reset_i       (reset_i),
        .debug_en_i    (debug_en_i),
        .trace_valid_i (trace_valid_i),
        .trace_addr_i  (trace_addr_i),
        .trace_insn_i  (trace_insn_i),
        .rd_req_i      (rd_req_i),
        .rd_cmd_i      (rd_cmd_i),
        .rd_index_i    (rd_index_i),
        .rd_ack_o      (rd_ack_o),
        .rd_data_o     (rd_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'b0, lcg_state[30:16]};
    endfunction

    // Status word as the readout port packs it
    function automatic logic [31:0] model_status();
        logic [31:0] s;
        s = '0;
        s[STATUS_WRAP_BIT] = model_wrapped;
        s[STATUS_PTR_LSB +: 8] = 8'(model_ptr);
        s[15:0] = model_wrapped ? 16'(DEPTH) : 16'(model_ptr);
        return s;
    endfunction

    function automatic logic [31:0] model_expect(logic [1:0] cmd, logic [IDX_W-1:0] idx);
        case (cmd)
            2'd0:    return model_addr[idx];
            2'd1:    return model_insn[idx];
            2'd2:    return model_status();
            default: return 32'd0;
        endcase
    endfunction

    task automatic note_failure(string msg);
        $display("%0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        test_checks++;
        assert (got == exp) else begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic load_golden();
        int               fd;
        int               code;
        byte              kind;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [8*128-1:0] rest;
        fd = $fopen("dv/trace_golden.txt", "r");
        if (fd == 0) begin
            note_failure("cannot open dv/trace_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    break;
                end
                golden_lines++;
                a = '0;
                b = '0;
                c = '0;
                if (kind == "#") begin
                    code = $fgets(rest, fd);
                end else if (kind == "T" || kind == "R") begin
                    code = $fscanf(fd, "%h %h %h", a, b, c);
                end else if (kind == "E") begin
                    code = $fscanf(fd, "%d", a);
                end else begin
                    note_failure("unknown operation kind in golden file");
                end
                if (kind == "T" || kind == "R" || kind == "E") begin
                    op_kind.push_back(kind);
                    op_a.push_back(a);
                    op_b.push_back(b);
                    op_c.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    // One packet, then one idle cycle so the write lands before the next op
    task automatic send_trace(logic en, logic [31:0] addr, logic [31:0] insn);
        @(posedge clk);
        debug_en_i    <= en;
        trace_valid_i <= 1'b1;
        trace_addr_i  <= addr;
        trace_insn_i  <= insn;
        @(posedge clk);
        trace_valid_i <= 1'b0;
        debug_en_i    <= 1'b0;
        if (en) begin
            model_addr[model_ptr] = addr;
            model_insn[model_ptr] = insn;
            if (&model_ptr) begin
                model_wrapped = 1'b1;
            end
            model_ptr = model_ptr + 1'b1;
        end
    endtask

    task automatic run_read(logic [1:0] cmd, logic [IDX_W-1:0] idx, logic [31:0] exp);
        logic [31:0] model_val;
        int          wait_cycles;
        int          hold;
        model_val = model_expect(cmd, idx);
        assert (exp == model_val) else begin
            note_failure($sformatf("golden value %h disagrees with ring model value %h",
                                   exp, model_val));
        end
        @(posedge clk);
        rd_req_i   <= 1'b1;
        rd_cmd_i   <= trace_cmd_e'(cmd);
        rd_index_i <= idx;
        // Request not yet sampled, so no ack may be seen here
        @(negedge clk);
        check_value("rd_ack_o", 32'(rd_ack_o), 32'd0);
        wait_cycles = 0;
        while (!rd_ack_o && wait_cycles < 8) begin
            @(negedge clk);
            wait_cycles++;
        end
        assert (rd_ack_o) else begin
            note_failure($sformatf("read command %0d was never acknowledged", cmd));
        end
        if (rd_ack_o) begin
            check_value("rd_data_o", rd_data_o, model_val);
            hold = next_random() % 8;
            repeat (hold) begin
                @(negedge clk);
                check_value("rd_ack_o", 32'(rd_ack_o), 32'd1);
                check_value("rd_data_o", rd_data_o, model_val);
            end
        end
        @(posedge clk);
        rd_req_i <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value("rd_ack_o", 32'(rd_ack_o), 32'd0);
        if (cmd == 2'd3) begin
            model_ptr     = '0;
            model_wrapped = 1'b0;
        end
    endtask

    // Watchdog sized from the golden file length
    initial begin
        wait (golden_loaded);
        #(golden_lines * 16 * 4);
        $display("Timeout after %0d ns, the run did not finish", golden_lines * 16 * 4);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset_i       = 1'b1;
        debug_en_i    = 1'b0;
        trace_valid_i = 1'b0;
        trace_addr_i  = '0;
        trace_insn_i  = '0;
        rd_req_i      = 1'b0;
        rd_cmd_i      = CMD_READ_ADDR;
        rd_index_i    = '0;
        lcg_state     = 32'd21;
        model_ptr     = '0;
        model_wrapped = 1'b0;
        load_golden();
        golden_loaded = 1'b1;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        // Readout port idles with zero data out of reset
        @(negedge clk);
        check_value("rd_ack_o", 32'(rd_ack_o), 32'd0);
        check_value("rd_data_o", rd_data_o, 32'd0);
        for (int i = 0; i < op_kind.size(); i++) begin
            if (op_kind[i] == "T") begin
                send_trace(op_a[i][0], op_b[i], op_c[i]);
            end else if (op_kind[i] == "R") begin
                run_read(op_a[i][1:0], op_b[i][IDX_W-1:0], op_c[i]);
            end else begin
                $display("test %0d finished: %0d checks, %0d errors",
                         op_a[i], test_checks, test_errors);
                tests++;
                test_checks = 0;
                test_errors = 0;
            end
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dv/trace_golden.txt
# T <debug_en> <addr> <insn>   R <cmd 0=addr 1=insn 2=status 3=clear> <index> <data>
# E <test number>
R 2 0 00000000
T 1 00001000 00000013
T 1 00001004 00500093
T 1 00001008 00a00113
R 0 0 00001000
R 1 0 00000013
R 0 1 00001004
R 1 1 00500093
R 0 2 00001008
R 1 2 00a00113
R 2 0 00030003
E 1
T 0 0000200c deadbeef
T 0 00002010 cafef00d
R 2 0 00030003
T 1 00001010 002081b3
R 2 0 00040004
R 0 3 00001010
R 1 3 002081b3
E 2
T 1 00001014 00310233
T 1 00001018 00418293
T 1 0000101c 00520313
T 1 00001020 00628393
T 1 00001024 00730433
T 1 00001028 008384b3
T 1 0000102c 00940533
R 0 0 00001024
R 1 0 00730433
R 0 1 00001028
R 0 2 0000102c
R 1 2 00940533
R 0 3 00001010
R 2 0 80030008
E 3
R 3 0 00000000
R 2 0 00000000
T 1 00003000 0000006f
R 0 0 00003000
R 1 0 0000006f
R 2 0 00010001
E 4
R 0 7 00001020
R 2 0 00010001
R 3 0 00000000
E 5

//--- src/mci_trace_pkg.sv
// MCU instruction trace subsystem definitions
// Word width, readout commands, reader states and status word layout

package mci_trace_pkg;

    // Width of trace address, instruction word and readout data
    localparam int TRACE_WORD_W = 32;

    // Readout commands
    typedef enum logic [1:0] {
        CMD_READ_ADDR   = 2'b00,
        CMD_READ_INSN   = 2'b01,
        CMD_READ_STATUS = 2'b10,
        CMD_CLEAR       = 2'b11
    } trace_cmd_e;

    // Four-phase readout handshake states
    typedef enum logic [1:0] {
        RD_IDLE   = 2'b00,
        RD_LOOKUP = 2'b01,
        RD_ACK    = 2'b10
    } reader_state_e;

    // Status word layout
    //   [31]    wrapped flag
    //   [23:16] write pointer
    //   [15:0]  entry count
    // Remaining bits read as zero
    localparam int STATUS_WRAP_BIT = 31;
    localparam int STATUS_PTR_LSB  = 16;

endpackage

//--- src/mci_trace_top.sv
// MCU instruction trace buffer
// Capture stage feeding a circular buffer, read back over a req/ack port
`timescale 1ns/1ns

module mci_trace_top
    import mci_trace_pkg::*;
#(
    parameter int TRACE_DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           reset_i,

    // Core trace port
    input  logic                           debug_en_i,
    input  logic                           trace_valid_i,
    input  logic [TRACE_WORD_W-1:0]        trace_addr_i,
    input  logic [TRACE_WORD_W-1:0]        trace_insn_i,

    // Readout port
    input  logic                           rd_req_i,
    input  trace_cmd_e                     rd_cmd_i,
    input  logic [$clog2(TRACE_DEPTH)-1:0] rd_index_i,
    output logic                           rd_ack_o,
    output logic [TRACE_WORD_W-1:0]        rd_data_o
);

    localparam int IDX_W = $clog2(TRACE_DEPTH);

    logic                    wr_en;
    logic [TRACE_WORD_W-1:0] wr_addr;
    logic [TRACE_WORD_W-1:0] wr_insn;
    logic                    clear;
    logic [IDX_W-1:0]        ring_index;
    logic [TRACE_WORD_W-1:0] entry_addr;
    logic [TRACE_WORD_W-1:0] entry_insn;
    logic [IDX_W-1:0]        wr_ptr;
    logic                    wrapped;
    logic [IDX_W:0]          count;

    trace_capture i_trace_capture (
        .clk           (clk),
        .reset_i       (reset_i),
        .debug_en_i    (debug_en_i),
        .trace_valid_i (trace_valid_i),
        .trace_addr_i  (trace_addr_i),
        .trace_insn_i  (trace_insn_i),
        .wr_en_o       (wr_en),
        .wr_addr_o     (wr_addr),
        .wr_insn_o     (wr_insn)
    );

    trace_ring #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) i_trace_ring (
        .clk          (clk),
        .reset_i      (reset_i),
        .wr_en_i      (wr_en),
        .wr_addr_i    (wr_addr),
        .wr_insn_i    (wr_insn),
        .clear_i      (clear),
        .rd_index_i   (ring_index),
        .entry_addr_o (entry_addr),
        .entry_insn_o (entry_insn),
        .wr_ptr_o     (wr_ptr),
        .wrapped_o    (wrapped),
        .count_o      (count)
    );

    trace_reader #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) i_trace_reader (
        .clk          (clk),
        .reset_i      (reset_i),
        .rd_req_i     (rd_req_i),
        .rd_cmd_i     (rd_cmd_i),
        .rd_index_i   (rd_index_i),
        .rd_ack_o     (rd_ack_o),
        .rd_data_o    (rd_data_o),
        .entry_addr_i (entry_addr),
        .entry_insn_i (entry_insn),
        .wr_ptr_i     (wr_ptr),
        .wrapped_i    (wrapped),
        .count_i      (count),
        .rd_index_o   (ring_index),
        .clear_o      (clear)
    );

endmodule

//--- src/trace_capture.sv
// Trace capture stage
// Keeps retired-instruction packets seen while debug is enabled
`timescale 1ns/1ns

module trace_capture
    import mci_trace_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,

    input  logic                    debug_en_i,
    input  logic                    trace_valid_i,
    input  logic [TRACE_WORD_W-1:0] trace_addr_i,
    input  logic [TRACE_WORD_W-1:0] trace_insn_i,

    // Write request to the ring
    output logic                    wr_en_o,
    output logic [TRACE_WORD_W-1:0] wr_addr_o,
    output logic [TRACE_WORD_W-1:0] wr_insn_o
);

    logic capture_en;

    // Packets outside debug never reach the buffer
    assign capture_en = trace_valid_i & debug_en_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= capture_en;
        end
    end

    // Packet fields only load for kept packets
    always_ff @(posedge clk) begin
        if (capture_en) begin
            wr_addr_o <= trace_addr_i;
            wr_insn_o <= trace_insn_i;
        end
    end

endmodule

//--- src/trace_reader.sv
// Trace readout responder
// Serves address, instruction, status and clear commands over four-phase req/ack
`timescale 1ns/1ns

module trace_reader
    import mci_trace_pkg::*;
#(
    parameter int TRACE_DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           reset_i,

    // Requester side
    input  logic                           rd_req_i,
    input  trace_cmd_e                     rd_cmd_i,
    input  logic [$clog2(TRACE_DEPTH)-1:0] rd_index_i,
    output logic                           rd_ack_o,
    output logic [TRACE_WORD_W-1:0]        rd_data_o,

    // Ring side
    input  logic [TRACE_WORD_W-1:0]        entry_addr_i,
    input  logic [TRACE_WORD_W-1:0]        entry_insn_i,
    input  logic [$clog2(TRACE_DEPTH)-1:0] wr_ptr_i,
    input  logic                           wrapped_i,
    input  logic [$clog2(TRACE_DEPTH):0]   count_i,
    output logic [$clog2(TRACE_DEPTH)-1:0] rd_index_o,
    output logic                           clear_o
);

    localparam int IDX_W = $clog2(TRACE_DEPTH);

    reader_state_e           state_q;
    trace_cmd_e              cmd_q;
    logic [IDX_W-1:0]        index_q;
    logic [TRACE_WORD_W-1:0] status_word;
    logic [TRACE_WORD_W-1:0] rsp_data;

    // Pack wrap flag, pointer and count
    always_comb begin
        status_word = '0;
        status_word[STATUS_WRAP_BIT] = wrapped_i;
        status_word[STATUS_PTR_LSB +: IDX_W] = wr_ptr_i;
        status_word[IDX_W:0] = count_i;
    end

    always_comb begin
        case (cmd_q)
            CMD_READ_ADDR:   rsp_data = entry_addr_i;
            CMD_READ_INSN:   rsp_data = entry_insn_i;
            CMD_READ_STATUS: rsp_data = status_word;
            default:         rsp_data = '0;
        endcase
    end

    // Command and index are taken on the first sample of req
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cmd_q   <= CMD_READ_ADDR;
            index_q <= '0;
        end else if (state_q == RD_IDLE && rd_req_i) begin
            cmd_q   <= rd_cmd_i;
            index_q <= rd_index_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= RD_IDLE;
            rd_ack_o  <= 1'b0;
            rd_data_o <= '0;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (rd_req_i) begin
                        state_q <= RD_LOOKUP;
                    end
                end
                RD_LOOKUP: begin
                    rd_data_o <= rsp_data;
                    rd_ack_o  <= 1'b1;
                    state_q   <= RD_ACK;
                end
                RD_ACK: begin
                    // Hold ack until the requester drops req
                    if (!rd_req_i) begin
                        rd_ack_o <= 1'b0;
                        state_q  <= RD_IDLE;
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    assign rd_index_o = index_q;
    // Lookup lasts one cycle, so this is a single-cycle strobe
    assign clear_o = (state_q == RD_LOOKUP) && (cmd_q == CMD_CLEAR);

endmodule

//--- src/trace_ring.sv
// Circular trace entry storage
// Newest packet overwrites the oldest once full; tracks pointer, wrap and count
`timescale 1ns/1ns

module trace_ring
    import mci_trace_pkg::*;
#(
    parameter int TRACE_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          reset_i,

    // Write side from capture
    input  logic                          wr_en_i,
    input  logic [TRACE_WORD_W-1:0]       wr_addr_i,
    input  logic [TRACE_WORD_W-1:0]       wr_insn_i,

    // Control and lookup from reader
    input  logic                          clear_i,
    input  logic [$clog2(TRACE_DEPTH)-1:0] rd_index_i,

    output logic [TRACE_WORD_W-1:0]       entry_addr_o,
    output logic [TRACE_WORD_W-1:0]       entry_insn_o,
    output logic [$clog2(TRACE_DEPTH)-1:0] wr_ptr_o,
    output logic                          wrapped_o,
    output logic [$clog2(TRACE_DEPTH):0]  count_o
);

    localparam int IDX_W = $clog2(TRACE_DEPTH);
    localparam logic [IDX_W:0] FULL_COUNT = (IDX_W+1)'(TRACE_DEPTH);

    logic [TRACE_WORD_W-1:0] addr_mem [TRACE_DEPTH];
    logic [TRACE_WORD_W-1:0] insn_mem [TRACE_DEPTH];
    logic [IDX_W-1:0]        wr_ptr_q;
    logic                    wrapped_q;
    logic                    do_write;

    // Clear wins over a same-cycle write
    assign do_write = wr_en_i & ~clear_i;

    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            wr_ptr_q  <= '0;
            wrapped_q <= 1'b0;
        end else if (wr_en_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
            // Last slot written, pointer rolls over to zero
            if (&wr_ptr_q) begin
                wrapped_q <= 1'b1;
            end
        end
    end

    // Entries survive a clear; only the bookkeeping is reset
    always_ff @(posedge clk) begin
        if (do_write) begin
            addr_mem[wr_ptr_q] <= wr_addr_i;
            insn_mem[wr_ptr_q] <= wr_insn_i;
        end
    end

    assign entry_addr_o = addr_mem[rd_index_i];
    assign entry_insn_o = insn_mem[rd_index_i];

    assign wr_ptr_o  = wr_ptr_q;
    assign wrapped_o = wrapped_q;
    // Pointer doubles as count until the first wrap
    assign count_o   = wrapped_q ? FULL_COUNT : {1'b0, wr_ptr_q};

endmodule

//--- verilog.f
src/mci_trace_pkg.sv
src/trace_capture.sv
src/trace_ring.sv
src/trace_reader.sv
src/mci_trace_top.sv
dv/tb_mci_trace.sv
